// File: run_sim.sh
#!/bin/sh
# Build and run the spec_fifo testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_spec_fifo \
   -f src.f \
   -o Vtb_spec_fifo

status=0
./obj_dir/Vtb_spec_fifo > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
if [ "$status" -ne 0 ]; then
   exit "$status"
fi

// File: src.f
src/spec_fifo_cfg_pkg.sv
src/spec_fifo_ctl_pkg.sv
src/fifo_store.sv
src/pipe_stage.sv
src/out_drain.sv
src/spec_fifo.sv
tb/tb_spec_fifo.sv

// File: src/fifo_store.sv
`timescale 1ns/10ps

module fifo_store
   import spec_fifo_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push,
   input  data_t data_in,
   input  logic  rd_en,
   output data_t head_data,
   output logic  head_valid,
   output logic  full
);

   // --------------------------------------------------
   // Storage and pointers.
   // --------------------------------------------------

   data_t  mem [DEPTH];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   count_t count;

   logic   empty;
   logic   wr_fire;
   logic   rd_fire;

   assign full    = (count == count_t'(DEPTH));
   assign empty   = (count == '0);

   // Pushes into a full buffer are dropped.
   assign wr_fire = push && !full;
   assign rd_fire = rd_en && !empty;

   // Head word is always visible to stage 0.
   assign head_data  = mem[rd_ptr];
   assign head_valid = !empty;

   // --------------------------------------------------
   // Write side.
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem[wr_ptr] <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (wr_fire) begin
         if (wr_ptr == ptr_t'(DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // Read side.
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (rd_fire) begin
         if (rd_ptr == ptr_t'(DEPTH - 1)) begin
            rd_ptr <= '0;
         end else begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy holds when a read and a write meet.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         case ({wr_fire, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // --------------------------------------------------
   // Checks.
   // --------------------------------------------------

   // Stage 0 only loads when the head is valid.
   a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> !empty);

   // Occupancy tracks the pointer distance and never passes DEPTH.
   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (count <= count_t'(DEPTH)) && (ptr_t'(wr_ptr - rd_ptr) == ptr_t'(count)));

endmodule

// File: src/out_drain.sv
`timescale 1ns/10ps

module out_drain
   import spec_fifo_cfg_pkg::*;
(
   input  logic              pop,
   input  logic              stall,
   input  logic              last_valid,
   input  logic [STAGES-1:0] stage_valid,
   input  logic              store_empty,
   output logic              take,
   output logic              empty
);

   // --------------------------------------------------
   // Consumer side.
   // --------------------------------------------------

   logic consume_ok;
   logic any_stage;

   // Stall freezes consumption, pop requests it.
   assign consume_ok = pop && !stall;

   // Last stage gives up its word only when it has one.
   assign take = consume_ok && last_valid;

   // --------------------------------------------------
   // Overall empty.
   // --------------------------------------------------

   // Words may still sit in the chain after the buffer drains.
   assign any_stage = |stage_valid;
   assign empty     = store_empty && !any_stage;

endmodule

// File: src/pipe_stage.sv
`timescale 1ns/10ps

module pipe_stage
   import spec_fifo_cfg_pkg::*;
   import spec_fifo_ctl_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_valid,
   input  data_t in_data,
   input  logic  take,
   output logic  load,
   output logic  out_valid,
   output data_t out_data
);

   // --------------------------------------------------
   // One-entry elastic register.
   // --------------------------------------------------

   stage_state_t state;
   data_t        word;

   // Refill while empty, or when the held word leaves at the same edge.
   assign load      = in_valid && ((state == STAGE_EMPTY) || take);
   assign out_valid = (state == STAGE_FULL);
   assign out_data  = word;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= STAGE_EMPTY;
      end else begin
         case (state)
            STAGE_EMPTY: begin
               if (load) begin
                  state <= STAGE_FULL;
               end
            end
            STAGE_FULL: begin
               // A take without a refill drains the stage.
               if (take && !load) begin
                  state <= STAGE_EMPTY;
               end
            end
            default: state <= STAGE_EMPTY;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         word <= in_data;
      end
   end

   // Downstream never takes from an empty stage.
   a_take_full: assert property (@(posedge clk) disable iff (!rst_n)
      take |-> (state == STAGE_FULL));

endmodule

// File: src/spec_fifo.sv
`timescale 1ns/10ps

module spec_fifo
   import spec_fifo_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push,
   input  data_t data_in,
   input  logic  pop,
   input  logic  stall,
   output data_t data_out,
   output logic  valid,
   output logic  full,
   output logic  empty
);

   // --------------------------------------------------
   // Chain wiring.
   // --------------------------------------------------

   data_t             head_data;
   logic              head_valid;
   logic              last_take;

   logic [STAGES-1:0] stage_valid;
   logic [STAGES-1:0] stage_load;
   logic [STAGES-1:0] stage_in_valid;
   logic [STAGES-1:0] stage_take;
   data_t             stage_in_data [STAGES];
   data_t             stage_data    [STAGES];

   fifo_store u_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push),
      .data_in    (data_in),
      .rd_en      (stage_load[0]),
      .head_data  (head_data),
      .head_valid (head_valid),
      .full       (full)
   );

   for (genvar k = 0; k < STAGES; k++) begin : g_stage
      // Stage 0 reads the buffer head, the rest read the stage before.
      if (k == 0) begin : g_first
         assign stage_in_valid[k] = head_valid;
         assign stage_in_data[k]  = head_data;
      end else begin : g_next
         assign stage_in_valid[k] = stage_valid[k-1];
         assign stage_in_data[k]  = stage_data[k-1];
      end

      // A stage's word is taken when the next stage loads it.
      if (k == STAGES - 1) begin : g_last
         assign stage_take[k] = last_take;
      end else begin : g_mid
         assign stage_take[k] = stage_load[k+1];
      end

      pipe_stage u_stage (
         .clk       (clk),
         .rst_n     (rst_n),
         .in_valid  (stage_in_valid[k]),
         .in_data   (stage_in_data[k]),
         .take      (stage_take[k]),
         .load      (stage_load[k]),
         .out_valid (stage_valid[k]),
         .out_data  (stage_data[k])
      );
   end

   out_drain u_drain (
      .pop         (pop),
      .stall       (stall),
      .last_valid  (stage_valid[STAGES-1]),
      .stage_valid (stage_valid),
      .store_empty (!head_valid),
      .take        (last_take),
      .empty       (empty)
   );

   assign data_out = stage_data[STAGES-1];
   assign valid    = stage_valid[STAGES-1];

endmodule

// File: src/spec_fifo_cfg_pkg.sv
package spec_fifo_cfg_pkg;

   // --------------------------------------------------
   // Geometry.
   // --------------------------------------------------

   // Width of one data word.
   localparam int DATA_W = 4;

   // Buffer entries, and output stages behind the buffer.
   localparam int DEPTH  = 16;
   localparam int STAGES = 3;

   // Pointer indexes DEPTH entries; counter holds 0 to DEPTH.
   localparam int PTR_W  = 4;
   localparam int CNT_W  = 5;

   // --------------------------------------------------
   // Types.
   // --------------------------------------------------

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [PTR_W-1:0]  ptr_t;
   typedef logic [CNT_W-1:0]  count_t;

endpackage

// File: src/spec_fifo_ctl_pkg.sv
package spec_fifo_ctl_pkg;

   // --------------------------------------------------
   // Output stage control.
   // --------------------------------------------------

   // A stage either holds a word or waits for one.
   typedef enum logic {
      STAGE_EMPTY = 1'b0,
      STAGE_FULL  = 1'b1
   } stage_state_t;

endpackage

// File: tb/spec_fifo_patterns.txt
// Record = 4 hex digits: push, pop, stall, data_in. One record per clock cycle.
// Layout: record count, records, expected word count, expected words in pop order.
005e

// Push and pop together from empty, then drain.
1101 1102 1103 1104
1105 1106 1107 1108
0100 0100 0100 0100
0100

// Pop held high while stall is raised for five cycles.
110a 110b 110c 111d
111e 111f 0110 0110
0100 0100 0100 0100
0100 0100 0100 0100

// Fill without popping, 19 words fit, the last two pushes are dropped.
1000 1001 1002 1003
1004 1005 1006 1007
1008 1009 100a 100b
100c 100d 100e 100f
1000 1001 1002
1009 1009
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100 0100 0100
0100 0100

// Streaming push and pop, full never rises.
1105 110a 1103 110c
1107 110e 1101 1108
110f 1102 1106 110b
1104 110d 1100 1109
0100 0100 0100 0100
0100 0100

// Expected word count.
0031

// Expected words.
0001 0002 0003 0004 0005 0006 0007 0008
000a 000b 000c 000d 000e 000f
0000 0001 0002 0003 0004 0005 0006 0007
0008 0009 000a 000b 000c 000d 000e 000f
0000 0001 0002
0005 000a 0003 000c 0007 000e 0001 0008
000f 0002 0006 000b 0004 000d 0000 0009

// File: tb/tb_spec_fifo.sv
`timescale 1ns/10ps

module tb_spec_fifo
   import spec_fifo_cfg_pkg::*;
();

   // --------------------------------------------------
   // Pattern memory and DUT signals.
   // --------------------------------------------------

   // Word 0 is the record count, then the records, then the
   // expected count and the expected words.
   localparam int PAT_WORDS = 256;

   logic [15:0] pat_mem [PAT_WORDS];

   logic  clk = 1'b0;
   logic  rst_n;
   logic  push;
   data_t data_in;
   logic  pop;
   logic  stall;
   data_t data_out;
   logic  valid;
   logic  full;
   logic  empty;

   int    n_rec;
   int    n_exp;
   int    exp_base;
   int    acc_cnt;
   int    rm_cnt;
   int    occ;
   int    cycle_cnt;
   logic  checking;
   logic  hold_valid;

   always #50 clk = ~clk;

   spec_fifo u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .data_in  (data_in),
      .pop      (pop),
      .stall    (stall),
      .data_out (data_out),
      .valid    (valid),
      .full     (full),
      .empty    (empty)
   );

   // --------------------------------------------------
   // Failure reporting.
   // --------------------------------------------------

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      fail_run($sformatf("[ERROR] time %0t: %s", $time, msg));
   endtask

   // --------------------------------------------------
   // Reference model at the falling edge.
   // --------------------------------------------------

   // Occupancy counts every word in the buffer and in the stages.
   always @(negedge clk) begin : model_check
      logic  accept;
      logic  remove;
      data_t exp_word;
      if (checking) begin
         accept = push && !full;
         remove = pop && !stall && valid;

         assert (empty == (occ == 0))
            else report_mismatch($sformatf("empty is %0b with %0d words held", empty, occ));
         assert (!full || occ >= DEPTH)
            else report_mismatch($sformatf("full is high with only %0d words held", occ));
         assert (occ != DEPTH + STAGES || full)
            else report_mismatch("full is low with buffer and stages all occupied");
         assert (!valid || occ > 0)
            else report_mismatch("valid is high while no word is held");
         // A presented word stays until it is removed.
         assert (!hold_valid || valid)
            else report_mismatch("valid dropped although the word was not removed");

         if (remove) begin
            assert (rm_cnt < n_exp)
               else report_mismatch("more words removed than expected");
            exp_word = pat_mem[exp_base + rm_cnt][DATA_W-1:0];
            assert (data_out == exp_word)
               else report_mismatch($sformatf("word %0d is %h, expected %h",
                                              rm_cnt, data_out, exp_word));
            rm_cnt = rm_cnt + 1;
         end

         if (accept) begin
            acc_cnt = acc_cnt + 1;
         end
         occ        = occ + (accept ? 1 : 0) - (remove ? 1 : 0);
         hold_valid = valid && !remove;
      end
   end

   // --------------------------------------------------
   // Timeout.
   // --------------------------------------------------

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= n_rec + 50) begin
         fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles.",
                            cycle_cnt));
      end
   end

   // --------------------------------------------------
   // Stimulus.
   // --------------------------------------------------

   initial begin
      rst_n      = 1'b0;
      push       = 1'b0;
      data_in    = '0;
      pop        = 1'b0;
      stall      = 1'b0;
      checking   = 1'b0;
      hold_valid = 1'b0;
      acc_cnt    = 0;
      rm_cnt     = 0;
      occ        = 0;

      $readmemh("tb/spec_fifo_patterns.txt", pat_mem);
      assert (!$isunknown(pat_mem[0]))
         else fail_run("The pattern file could not be read.");
      n_rec    = int'(pat_mem[0]);
      exp_base = n_rec + 2;
      assert (exp_base < PAT_WORDS && !$isunknown(pat_mem[n_rec + 1]))
         else fail_run("The pattern file has no expected word count.");
      n_exp = int'(pat_mem[n_rec + 1]);
      assert (exp_base + n_exp <= PAT_WORDS)
         else fail_run("The pattern file holds more words than the testbench can load.");

      repeat (2) @(posedge clk);
      rst_n    <= 1'b1;
      checking <= 1'b1;

      @(negedge clk);
      assert (!valid && empty && !full)
         else report_mismatch("outputs are not idle after reset");

      // Record bits are push, pop and stall in the upper digits, data in the low digit.
      for (int i = 1; i <= n_rec; i++) begin
         @(posedge clk);
         push    <= pat_mem[i][12];
         pop     <= pat_mem[i][8];
         stall   <= pat_mem[i][4];
         data_in <= pat_mem[i][DATA_W-1:0];
      end

      @(posedge clk);
      push  <= 1'b0;
      pop   <= 1'b0;
      stall <= 1'b0;
      @(posedge clk);

      assert (acc_cnt == n_exp)
         else report_mismatch($sformatf("%0d pushes accepted, expected %0d", acc_cnt, n_exp));
      assert (rm_cnt == n_exp)
         else report_mismatch($sformatf("%0d words removed, expected %0d", rm_cnt, n_exp));
      assert (occ == 0)
         else report_mismatch($sformatf("%0d words left after the drain", occ));

      $display("All tests passed");
      $finish;
   end

endmodule
